//--- csr_unit.f
src/csr_pkg.sv
src/csr_access_decode.sv
src/hpm_counter.sv
src/csr_trap_regs.sv
src/csr_read_mux.sv
src/csr_unit.sv
tests/csr_unit_checker.sv
tests/csr_unit_tb.sv

//--- tests/csr_unit_tb.sv
module csr_unit_tb;

    localparam int N_OPS         = 64;
    localparam int N_INSTRET     = 48;
    localparam int TEST_CYCLES   = 4 + 12 + (N_OPS + 6) + (N_INSTRET + 14) + 30 + 28;
    localparam int WATCHDOG_TIME = 10 * (TEST_CYCLES + 50);

    logic              clk;
    logic              rst_n;
    csr_pkg::csr_req_t req;
    logic              instr_fin;
    logic [31:0]       execute_pc;
    logic              ext_irq;
    logic              sw_irq;
    logic [31:0]       rdata;
    csr_pkg::trap_t    trap;

    int          errors;
    int          total_fails;
    logic [31:0] ref_regs [3];  // Model of mscratch, mtvec, mie.
    logic [11:0] ref_addr [3];
    logic [31:0] ref_mstatus;

    csr_unit #(
        .CLK_FREQ (50_000_000)
    ) i_csr_unit (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .req_i                  (req),
        .instruction_finished_i (instr_fin),
        .execute_pc_i           (execute_pc),
        .ext_irq_i              (ext_irq),
        .sw_irq_i               (sw_irq),
        .csr_rdata_o            (rdata),
        .trap_o                 (trap)
    );

    always #5 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One request per cycle; the old value is sampled once it has settled.
    task automatic access_csr(input logic [11:0] addr, input logic [2:0] funct3,
                              input logic wr_en, input logic [31:0] rs1,
                              input logic [4:0] imm, output logic [31:0] old);
        @(negedge clk);
        req.wr_en    = wr_en;
        req.funct3   = funct3;
        req.imm      = imm;
        req.addr     = addr;
        req.rs1_data = rs1;
        #1;
        old = rdata;
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] old;
        access_csr(addr, 3'b001, 1'b1, data, 5'd0, old);
    endtask

    task automatic expect_read(input string name, input logic [11:0] addr,
                               input logic [31:0] expected);
        logic [31:0] old;
        access_csr(addr, 3'b010, 1'b0, 32'd0, 5'd0, old);
        compare_value(name, expected, old);
    endtask

    task automatic watch_no_trap(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_value(name, 32'd0, {31'd0, trap.taken});
            req = '0;
        end
    endtask

    // New register value after one CSR instruction.
    function automatic logic [31:0] apply_op(logic [31:0] old_val, logic [2:0] funct3,
                                             logic wr_en, logic [31:0] rs1, logic [4:0] imm);
        logic [31:0] operand;
        operand = funct3[2] ? {27'd0, imm} : rs1;
        if (!wr_en) begin
            return old_val;
        end
        case (funct3[1:0])
            2'b01:   return operand;
            2'b10:   return old_val | operand;
            2'b11:   return old_val & ~operand;
            default: return old_val;
        endcase
    endfunction

    task automatic constant_registers();
        expect_read("misa", csr_pkg::ADDR_MISA, csr_pkg::MISA_VALUE);
        expect_read("clock frequency", csr_pkg::ADDR_MHZFREQ, 32'd50_000_000);
        expect_read("mvendorid", csr_pkg::ADDR_MVENDORID, 32'd0);
        expect_read("marchid", csr_pkg::ADDR_MARCHID, 32'd0);
        expect_read("mimpid", csr_pkg::ADDR_MIMPID, 32'd0);
        expect_read("mhartid", csr_pkg::ADDR_MHARTID, 32'd0);
        expect_read("time", csr_pkg::ADDR_TIME, 32'd0);
        expect_read("timeh", csr_pkg::ADDR_TIMEH, 32'd0);
        expect_read("unmapped", 12'h7C0, 32'd0);
    endtask

    task automatic random_csr_ops();
        int          idx;
        logic [2:0]  funct3;
        logic        wr_en;
        logic [31:0] rs1;
        logic [4:0]  imm;
        logic [31:0] old;
        for (int i = 0; i < N_OPS; i++) begin
            idx    = $urandom_range(0, 2);
            funct3 = 3'($urandom_range(0, 7));
            wr_en  = ($urandom_range(0, 7) != 0);
            rs1    = $urandom;
            imm    = 5'($urandom);
            access_csr(ref_addr[idx], funct3, wr_en, rs1, imm, old);
            compare_value($sformatf("csr op %0d", i), ref_regs[idx], old);
            ref_regs[idx] = apply_op(ref_regs[idx], funct3, wr_en, rs1, imm);
        end
        for (int i = 0; i < 3; i++) begin
            expect_read($sformatf("csr final %0d", i), ref_addr[i], ref_regs[i]);
        end
    endtask

    task automatic counter_behavior();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] value;
        logic [31:0] start;
        logic        pulse;
        int          pulses;
        access_csr(csr_pkg::ADDR_MCYCLE, 3'b010, 1'b0, 32'd0, 5'd0, first);
        access_csr(csr_pkg::ADDR_MCYCLE, 3'b010, 1'b0, 32'd0, 5'd0, second);
        compare_value("mcycle step", first + 32'd1, second);
        value = $urandom;
        write_csr(csr_pkg::ADDR_MCYCLEH, value);
        expect_read("mcycleh write", csr_pkg::ADDR_MCYCLEH, value);
        expect_read("cycleh alias", csr_pkg::ADDR_CYCLEH, value);
        start = $urandom & 32'h7FFF_FFFF;  // Keeps the sum inside the low half.
        write_csr(csr_pkg::ADDR_MINSTRET, start);
        pulses = 0;
        repeat (N_INSTRET) begin
            @(negedge clk);
            req       = '0;
            pulse     = 1'($urandom_range(0, 1));
            instr_fin = pulse;
            pulses   += pulse;
        end
        @(negedge clk);
        instr_fin = 1'b0;
        expect_read("minstret count", csr_pkg::ADDR_MINSTRET, start + 32'(pulses));
        expect_read("instret alias", csr_pkg::ADDR_INSTRET, start + 32'(pulses));
        // User aliases are read only.
        access_csr(csr_pkg::ADDR_CYCLE, 3'b001, 1'b1, 32'hFFFF_FFF0, 5'd0, first);
        expect_read("cycle alias write", csr_pkg::ADDR_MCYCLE, first + 32'd1);
        access_csr(csr_pkg::ADDR_INSTRET, 3'b001, 1'b1, $urandom, 5'd0, first);
        expect_read("instret alias write", csr_pkg::ADDR_MINSTRET, first);
        access_csr(csr_pkg::ADDR_INSTRETH, 3'b001, 1'b1, $urandom, 5'd0, first);
        expect_read("instreth alias write", csr_pkg::ADDR_MINSTRETH, first);
    endtask

    task automatic interrupt_entry(input string name, input logic ext, input logic sw,
                                   input logic [31:0] tvec, input logic [31:0] exp_cause,
                                   input logic [31:0] exp_pc);
        logic [31:0] entry_pc;
        logic [31:0] exp_status;
        write_csr(csr_pkg::ADDR_MTVEC, tvec);
        write_csr(csr_pkg::ADDR_MIE, 32'h0000_0808);
        write_csr(csr_pkg::ADDR_MSTATUS, 32'h0000_0008);
        ref_mstatus = 32'h0000_0008;
        @(negedge clk);
        req        = '0;
        ext_irq    = ext;
        sw_irq     = sw;
        execute_pc = $urandom & 32'hFFFF_FFFC;
        @(negedge clk);  // Inputs now pending in mip.
        compare_value($sformatf("%s early", name), 32'd0, {31'd0, trap.taken});
        entry_pc   = $urandom & 32'hFFFF_FFFC;
        execute_pc = entry_pc;
        @(negedge clk);  // Entry edge has passed.
        compare_value($sformatf("%s taken", name), 32'd1, {31'd0, trap.taken});
        compare_value($sformatf("%s target", name), exp_pc, trap.pc);
        ext_irq = 1'b0;
        sw_irq  = 1'b0;
        exp_status = ref_mstatus;
        exp_status[csr_pkg::MSTATUS_MPIE_BIT] = ref_mstatus[csr_pkg::MSTATUS_MIE_BIT];
        exp_status[csr_pkg::MSTATUS_MIE_BIT]  = 1'b0;
        ref_mstatus = exp_status;
        expect_read($sformatf("%s mepc", name), csr_pkg::ADDR_MEPC, entry_pc);
        expect_read($sformatf("%s mcause", name), csr_pkg::ADDR_MCAUSE, exp_cause);
        expect_read($sformatf("%s mstatus", name), csr_pkg::ADDR_MSTATUS, exp_status);
    endtask

    task automatic masking_and_mip();
        logic [31:0] old;
        write_csr(csr_pkg::ADDR_MSTATUS, 32'd0);  // Global enable off.
        write_csr(csr_pkg::ADDR_MIE, 32'h0000_0808);
        @(negedge clk);
        req     = '0;
        ext_irq = 1'b1;
        sw_irq  = 1'b1;
        watch_no_trap("mstatus mie off", 3);
        expect_read("mip inputs", csr_pkg::ADDR_MIP, 32'h0000_0808);
        access_csr(csr_pkg::ADDR_MIP, 3'b001, 1'b1, 32'd0, 5'd0, old);
        compare_value("mip old value", 32'h0000_0808, old);
        expect_read("mip write ignored", csr_pkg::ADDR_MIP, 32'h0000_0808);
        write_csr(csr_pkg::ADDR_MIE, 32'd0);      // Enable bits off first.
        write_csr(csr_pkg::ADDR_MSTATUS, 32'h0000_0008);
        watch_no_trap("mie bits off", 4);
        @(negedge clk);
        ext_irq = 1'b0;
        sw_irq  = 1'b0;
        watch_no_trap("mip drain", 1);
        expect_read("mip cleared", csr_pkg::ADDR_MIP, 32'd0);
        write_csr(csr_pkg::ADDR_MIP, 32'hFFFF_FFFF);
        expect_read("mip set ignored", csr_pkg::ADDR_MIP, 32'd0);
    endtask

    initial begin
        void'($urandom(32'h9565));
        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = '0;
        instr_fin   = 1'b0;
        execute_pc  = 32'd0;
        ext_irq     = 1'b0;
        sw_irq      = 1'b0;
        errors      = 0;
        ref_regs    = '{default: '0};
        ref_mstatus = 32'd0;
        ref_addr[0] = csr_pkg::ADDR_MSCRATCH;
        ref_addr[1] = csr_pkg::ADDR_MTVEC;
        ref_addr[2] = csr_pkg::ADDR_MIE;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        constant_registers();
        random_csr_ops();
        counter_behavior();
        interrupt_entry("irq direct", 1'b1, 1'b0, 32'h0000_1002, 32'h8000_000B, 32'h0000_1000);
        interrupt_entry("irq vectored", 1'b0, 1'b1, 32'h0000_3001, 32'h8000_0003, 32'h0000_300C);
        interrupt_entry("irq priority", 1'b1, 1'b1, 32'h0000_4001, 32'h8000_000B, 32'h0000_402C);
        masking_and_mip();
        watch_no_trap("final idle", 3);

        total_fails = errors + i_csr_unit.i_checker.fail_count;
        $display("errors: %0d in port checks, %0d in bound assertions",
                 errors, i_csr_unit.i_checker.fail_count);
        if (total_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Ends a run that stalls well past the expected length.
    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before the stimulus finished");
        $display("tests failed");
        $finish;
    end

endmodule

//--- tests/csr_unit_checker.sv
module csr_unit_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                ext_irq_i,
    input logic                sw_irq_i,
    input csr_pkg::trap_csrs_t csrs_i,
    input csr_pkg::trap_t      trap_i
);

    int unsigned fail_count = 0; // Summed by the testbench at the end.

    // Target rule: base with low bits cleared, plus 4 * cause in vectored mode.
    function automatic logic [31:0] expected_target(logic [31:0] mtvec, logic [31:0] mcause);
        logic [31:0] base;
        base = {mtvec[31:2], 2'b00};
        if (mtvec[0]) begin
            return base + {25'd0, mcause[4:0], 2'b00};
        end
        return base;
    endfunction

    taken_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        trap_i.taken |=> !trap_i.taken)
    else begin
        fail_count++;
        $error("trap pulse stayed high for two cycles");
    end

    // MIE has been cleared by the entry edge.
    mie_cleared: assert property (@(posedge clk) disable iff (!rst_n)
        trap_i.taken |-> !csrs_i.mstatus[csr_pkg::MSTATUS_MIE_BIT])
    else begin
        fail_count++;
        $error("mstatus MIE still set while the trap pulse is out");
    end

    target_pc: assert property (@(posedge clk) disable iff (!rst_n)
        trap_i.taken |-> csrs_i.mcause[31]
                         && trap_i.pc == expected_target(csrs_i.mtvec, csrs_i.mcause))
    else begin
        fail_count++;
        $error("trap target pc does not follow mtvec and mcause");
    end

    mip_follows_inputs: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> csrs_i.mip[csr_pkg::MIx_MEI_BIT] == $past(ext_irq_i)
                         && csrs_i.mip[csr_pkg::MIx_MSI_BIT] == $past(sw_irq_i))
    else begin
        fail_count++;
        $error("mip pending bits do not match the interrupt inputs of the last cycle");
    end

endmodule

bind csr_unit csr_unit_checker i_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .ext_irq_i (ext_irq_i),
    .sw_irq_i  (sw_irq_i),
    .csrs_i    (csrs),
    .trap_i    (trap_o)
);

//--- src/csr_unit.sv
module csr_unit #(
    parameter int unsigned CLK_FREQ = 100_000_000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  csr_pkg::csr_req_t req_i,
    input  logic              instruction_finished_i,
    input  logic [31:0]       execute_pc_i,
    input  logic              ext_irq_i,
    input  logic              sw_irq_i,
    output logic [31:0]       csr_rdata_o,
    output csr_pkg::trap_t    trap_o
);

    csr_pkg::csr_sel_e          sel;
    csr_pkg::csr_wr_t           wr;
    csr_pkg::trap_csrs_t        csrs;
    csr_pkg::cnt_array_t        counts;
    logic [csr_pkg::NUM_HPM-1:0] cnt_wr_lo;
    logic [csr_pkg::NUM_HPM-1:0] cnt_wr_hi;
    logic [csr_pkg::NUM_HPM-1:0] cnt_inc;
    logic [31:0]                rdata;

    csr_access_decode i_decode (
        .req_i       (req_i),
        .rdata_i     (rdata),
        .sel_o       (sel),
        .wr_o        (wr),
        .cnt_wr_lo_o (cnt_wr_lo),
        .cnt_wr_hi_o (cnt_wr_hi)
    );

    for (genvar g = 0; g < csr_pkg::NUM_HPM; g++) begin : g_hpm
        // The cycle counter runs every clock.
        assign cnt_inc[g] = (g == csr_pkg::CNT_CYCLE) ? 1'b1 : instruction_finished_i;

        hpm_counter i_counter (
            .clk     (clk),
            .rst_n   (rst_n),
            .inc_i   (cnt_inc[g]),
            .wr_lo_i (cnt_wr_lo[g]),
            .wr_hi_i (cnt_wr_hi[g]),
            .wdata_i (wr.data),
            .count_o (counts[g])
        );
    end

    csr_trap_regs i_trap_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_i         (wr),
        .execute_pc_i (execute_pc_i),
        .ext_irq_i    (ext_irq_i),
        .sw_irq_i     (sw_irq_i),
        .csrs_o       (csrs),
        .trap_o       (trap_o)
    );

    csr_read_mux #(
        .CLK_FREQ (CLK_FREQ)
    ) i_read_mux (
        .sel_i    (sel),
        .csrs_i   (csrs),
        .counts_i (counts),
        .rdata_o  (rdata)
    );

    assign csr_rdata_o = rdata; // Old value, same cycle.

endmodule

//--- src/csr_read_mux.sv
module csr_read_mux #(
    parameter int unsigned CLK_FREQ = 100_000_000
) (
    input  csr_pkg::csr_sel_e   sel_i,
    input  csr_pkg::trap_csrs_t csrs_i,
    input  csr_pkg::cnt_array_t counts_i,
    output logic [31:0]         rdata_o
);

    logic [63:0] cycle_cnt;
    logic [63:0] instret_cnt;

    assign cycle_cnt   = counts_i[csr_pkg::CNT_CYCLE];
    assign instret_cnt = counts_i[csr_pkg::CNT_INSTRET];

    always_comb begin
        case (sel_i)
            // Trap setup and handling.
            csr_pkg::SEL_MSTATUS:   rdata_o = csrs_i.mstatus;
            csr_pkg::SEL_MIE:       rdata_o = csrs_i.mie;
            csr_pkg::SEL_MTVEC:     rdata_o = csrs_i.mtvec;
            csr_pkg::SEL_MSCRATCH:  rdata_o = csrs_i.mscratch;
            csr_pkg::SEL_MEPC:      rdata_o = csrs_i.mepc;
            csr_pkg::SEL_MCAUSE:    rdata_o = csrs_i.mcause;
            csr_pkg::SEL_MTVAL:     rdata_o = csrs_i.mtval;
            csr_pkg::SEL_MIP:       rdata_o = csrs_i.mip;

            // Counters, machine and user views share the value.
            csr_pkg::SEL_MCYCLE,
            csr_pkg::SEL_CYCLE:     rdata_o = cycle_cnt[31:0];
            csr_pkg::SEL_MCYCLEH,
            csr_pkg::SEL_CYCLEH:    rdata_o = cycle_cnt[63:32];
            csr_pkg::SEL_MINSTRET,
            csr_pkg::SEL_INSTRET:   rdata_o = instret_cnt[31:0];
            csr_pkg::SEL_MINSTRETH,
            csr_pkg::SEL_INSTRETH:  rdata_o = instret_cnt[63:32];

            csr_pkg::SEL_MISA:      rdata_o = csr_pkg::MISA_VALUE;
            csr_pkg::SEL_MHZFREQ:   rdata_o = 32'(CLK_FREQ);

            // Time, IDs, mstatush and unmapped addresses.
            default:                rdata_o = 32'd0;
        endcase
    end

endmodule

//--- src/csr_trap_regs.sv
module csr_trap_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_wr_t    wr_i,
    input  logic [31:0]         execute_pc_i,
    input  logic                ext_irq_i,
    input  logic                sw_irq_i,
    output csr_pkg::trap_csrs_t csrs_o,
    output csr_pkg::trap_t      trap_o
);

    csr_pkg::trap_csrs_t csrs_q;
    csr_pkg::trap_t      trap_q;

    logic        ext_take;
    logic        sw_take;
    logic        irq_take;
    logic [4:0]  cause_code;
    logic [31:0] tvec_base;
    logic [31:0] trap_pc;
    logic [31:0] mip_next;

    // Pending and enabled, gated by the global enable.
    assign ext_take = csrs_q.mstatus[csr_pkg::MSTATUS_MIE_BIT]
                    & csrs_q.mie[csr_pkg::MIx_MEI_BIT]
                    & csrs_q.mip[csr_pkg::MIx_MEI_BIT];
    assign sw_take  = csrs_q.mstatus[csr_pkg::MSTATUS_MIE_BIT]
                    & csrs_q.mie[csr_pkg::MIx_MSI_BIT]
                    & csrs_q.mip[csr_pkg::MIx_MSI_BIT];
    assign irq_take = ext_take | sw_take;

    // External first.
    assign cause_code = ext_take ? 5'(csr_pkg::MIx_MEI_BIT) : 5'(csr_pkg::MIx_MSI_BIT);

    assign tvec_base = {csrs_q.mtvec[31:2], 2'b00};
    assign trap_pc   = csrs_q.mtvec[0] ? tvec_base + {25'd0, cause_code, 2'b00}
                                       : tvec_base;

    // Only MEIP and MSIP exist in mip.
    always_comb begin
        mip_next = '0;
        mip_next[csr_pkg::MIx_MEI_BIT] = ext_irq_i;
        mip_next[csr_pkg::MIx_MSI_BIT] = sw_irq_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csrs_q <= '0;
        end else begin
            csrs_q.mip <= mip_next;
            if (irq_take) begin
                // Trap entry. A CSR write on this edge is lost.
                csrs_q.mepc   <= execute_pc_i;
                csrs_q.mcause <= {1'b1, 26'd0, cause_code};
                csrs_q.mstatus[csr_pkg::MSTATUS_MPIE_BIT] <=
                    csrs_q.mstatus[csr_pkg::MSTATUS_MIE_BIT];
                csrs_q.mstatus[csr_pkg::MSTATUS_MIE_BIT] <= 1'b0;
            end else if (wr_i.en) begin
                case (wr_i.sel)
                    csr_pkg::SEL_MSTATUS:  csrs_q.mstatus  <= wr_i.data;
                    csr_pkg::SEL_MIE:      csrs_q.mie      <= wr_i.data;
                    csr_pkg::SEL_MTVEC:    csrs_q.mtvec    <= wr_i.data;
                    csr_pkg::SEL_MSCRATCH: csrs_q.mscratch <= wr_i.data;
                    csr_pkg::SEL_MEPC:     csrs_q.mepc     <= wr_i.data;
                    csr_pkg::SEL_MCAUSE:   csrs_q.mcause   <= wr_i.data;
                    csr_pkg::SEL_MTVAL:    csrs_q.mtval    <= wr_i.data;
                    default: ;  // Counters live elsewhere.
                endcase
            end
        end
    end

    // One-cycle pulse; MIE is already clear after it.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trap_q <= '0;
        end else begin
            trap_q.taken <= irq_take;
            trap_q.pc    <= trap_pc;
        end
    end

    assign csrs_o = csrs_q;
    assign trap_o = trap_q;

endmodule

//--- src/hpm_counter.sv
module hpm_counter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inc_i,
    input  logic        wr_lo_i,
    input  logic        wr_hi_i,
    input  logic [31:0] wdata_i,
    output logic [63:0] count_o
);

    logic [63:0] count_q;

    // A half-word write wins over the increment on the same edge.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= 64'd0;
        end else if (wr_lo_i) begin
            count_q[31:0] <= wdata_i;
        end else if (wr_hi_i) begin
            count_q[63:32] <= wdata_i;
        end else if (inc_i) begin
            count_q <= count_q + 64'd1;
        end
    end

    assign count_o = count_q;

endmodule

//--- src/csr_access_decode.sv
module csr_access_decode (
    input  csr_pkg::csr_req_t      req_i,
    input  logic [31:0]            rdata_i,
    output csr_pkg::csr_sel_e      sel_o,
    output csr_pkg::csr_wr_t       wr_o,
    output logic [csr_pkg::NUM_HPM-1:0] cnt_wr_lo_o,
    output logic [csr_pkg::NUM_HPM-1:0] cnt_wr_hi_o
);

    csr_pkg::csr_sel_e sel;
    logic              writable;
    logic              wr_en;
    logic [31:0]       operand;
    logic [31:0]       result;

    always_comb begin
        case (req_i.addr)
            csr_pkg::ADDR_MSTATUS:   sel = csr_pkg::SEL_MSTATUS;
            csr_pkg::ADDR_MIE:       sel = csr_pkg::SEL_MIE;
            csr_pkg::ADDR_MTVEC:     sel = csr_pkg::SEL_MTVEC;
            csr_pkg::ADDR_MSCRATCH:  sel = csr_pkg::SEL_MSCRATCH;
            csr_pkg::ADDR_MEPC:      sel = csr_pkg::SEL_MEPC;
            csr_pkg::ADDR_MCAUSE:    sel = csr_pkg::SEL_MCAUSE;
            csr_pkg::ADDR_MTVAL:     sel = csr_pkg::SEL_MTVAL;
            csr_pkg::ADDR_MIP:       sel = csr_pkg::SEL_MIP;
            csr_pkg::ADDR_MCYCLE:    sel = csr_pkg::SEL_MCYCLE;
            csr_pkg::ADDR_MCYCLEH:   sel = csr_pkg::SEL_MCYCLEH;
            csr_pkg::ADDR_MINSTRET:  sel = csr_pkg::SEL_MINSTRET;
            csr_pkg::ADDR_MINSTRETH: sel = csr_pkg::SEL_MINSTRETH;
            csr_pkg::ADDR_CYCLE:     sel = csr_pkg::SEL_CYCLE;    // User aliases, read only.
            csr_pkg::ADDR_CYCLEH:    sel = csr_pkg::SEL_CYCLEH;
            csr_pkg::ADDR_INSTRET:   sel = csr_pkg::SEL_INSTRET;
            csr_pkg::ADDR_INSTRETH:  sel = csr_pkg::SEL_INSTRETH;
            csr_pkg::ADDR_TIME,
            csr_pkg::ADDR_TIMEH,
            csr_pkg::ADDR_TIMECMP:   sel = csr_pkg::SEL_TIME;     // Not implemented, reads zero.
            csr_pkg::ADDR_MISA:      sel = csr_pkg::SEL_MISA;
            csr_pkg::ADDR_MVENDORID: sel = csr_pkg::SEL_MVENDORID;
            csr_pkg::ADDR_MARCHID:   sel = csr_pkg::SEL_MARCHID;
            csr_pkg::ADDR_MIMPID:    sel = csr_pkg::SEL_MIMPID;
            csr_pkg::ADDR_MHARTID:   sel = csr_pkg::SEL_MHARTID;
            csr_pkg::ADDR_MSTATUSH:  sel = csr_pkg::SEL_MSTATUSH;
            csr_pkg::ADDR_MHZFREQ:   sel = csr_pkg::SEL_MHZFREQ;
            default:                 sel = csr_pkg::SEL_NONE;
        endcase
    end

    // Only the machine registers and machine counter halves accept writes.
    always_comb begin
        case (sel)
            csr_pkg::SEL_MSTATUS, csr_pkg::SEL_MIE, csr_pkg::SEL_MTVEC,
            csr_pkg::SEL_MSCRATCH, csr_pkg::SEL_MEPC, csr_pkg::SEL_MCAUSE,
            csr_pkg::SEL_MTVAL, csr_pkg::SEL_MCYCLE, csr_pkg::SEL_MCYCLEH,
            csr_pkg::SEL_MINSTRET, csr_pkg::SEL_MINSTRETH: writable = 1'b1;
            default:                                        writable = 1'b0;
        endcase
    end

    assign operand = req_i.funct3[2] ? {27'd0, req_i.imm} : req_i.rs1_data;

    always_comb begin
        case (req_i.funct3[1:0])
            2'b01:   result = operand;
            2'b10:   result = rdata_i | operand;
            2'b11:   result = rdata_i & ~operand;
            default: result = rdata_i;
        endcase
    end

    assign wr_en = req_i.wr_en & writable & (req_i.funct3[1:0] != 2'b00);

    always_comb begin
        cnt_wr_lo_o = '0;
        cnt_wr_hi_o = '0;
        if (wr_en) begin
            case (sel)
                csr_pkg::SEL_MCYCLE:    cnt_wr_lo_o[csr_pkg::CNT_CYCLE]   = 1'b1;
                csr_pkg::SEL_MCYCLEH:   cnt_wr_hi_o[csr_pkg::CNT_CYCLE]   = 1'b1;
                csr_pkg::SEL_MINSTRET:  cnt_wr_lo_o[csr_pkg::CNT_INSTRET] = 1'b1;
                csr_pkg::SEL_MINSTRETH: cnt_wr_hi_o[csr_pkg::CNT_INSTRET] = 1'b1;
                default: ;
            endcase
        end
    end

    assign sel_o     = sel;
    assign wr_o.en   = wr_en;
    assign wr_o.sel  = sel;
    assign wr_o.data = result;

endmodule

//--- src/csr_pkg.sv
package csr_pkg;

    // Performance counters, user aliases.
    localparam logic [11:0] ADDR_CYCLE     = 12'hC00;
    localparam logic [11:0] ADDR_TIME      = 12'hC01;
    localparam logic [11:0] ADDR_INSTRET   = 12'hC02;
    localparam logic [11:0] ADDR_CYCLEH    = 12'hC80;
    localparam logic [11:0] ADDR_TIMEH     = 12'hC81;
    localparam logic [11:0] ADDR_INSTRETH  = 12'hC82;
    localparam logic [11:0] ADDR_TIMECMP   = 12'hFFF;

    // Machine information.
    localparam logic [11:0] ADDR_MISA      = 12'h301;
    localparam logic [11:0] ADDR_MVENDORID = 12'hF11;
    localparam logic [11:0] ADDR_MARCHID   = 12'hF12;
    localparam logic [11:0] ADDR_MIMPID    = 12'hF13;
    localparam logic [11:0] ADDR_MHARTID   = 12'hF14;

    // Machine trap setup and handling.
    localparam logic [11:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [11:0] ADDR_MSTATUSH  = 12'h310;
    localparam logic [11:0] ADDR_MIE       = 12'h304;
    localparam logic [11:0] ADDR_MTVEC     = 12'h305;
    localparam logic [11:0] ADDR_MSCRATCH  = 12'h340;
    localparam logic [11:0] ADDR_MEPC      = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE    = 12'h342;
    localparam logic [11:0] ADDR_MTVAL     = 12'h343;
    localparam logic [11:0] ADDR_MIP       = 12'h344;

    // Machine counters, writable halves.
    localparam logic [11:0] ADDR_MCYCLE    = 12'hB00;
    localparam logic [11:0] ADDR_MINSTRET  = 12'hB02;
    localparam logic [11:0] ADDR_MCYCLEH   = 12'hB80;
    localparam logic [11:0] ADDR_MINSTRETH = 12'hB82;

    localparam logic [11:0] ADDR_MHZFREQ   = 12'hFC1; // Custom, clock frequency in Hz.

    localparam logic [31:0] MISA_VALUE = 32'h4000_1107; // MXL=1, I M A B C.

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIx_MSI_BIT      = 3;  // Also the cause code.
    localparam int MIx_MEI_BIT      = 11;

    localparam int NUM_HPM     = 2;
    localparam int CNT_CYCLE   = 0;
    localparam int CNT_INSTRET = 1;

    typedef struct packed {
        logic        wr_en;
        logic [2:0]  funct3;
        logic [4:0]  imm;
        logic [11:0] addr;
        logic [31:0] rs1_data;
    } csr_req_t;

    typedef enum logic [4:0] {
        SEL_NONE, SEL_MSTATUS, SEL_MIE, SEL_MTVEC, SEL_MSCRATCH,
        SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MCYCLE, SEL_MCYCLEH,
        SEL_MINSTRET, SEL_MINSTRETH, SEL_MIP, SEL_CYCLE, SEL_CYCLEH,
        SEL_INSTRET, SEL_INSTRETH, SEL_TIME, SEL_MISA, SEL_MVENDORID,
        SEL_MARCHID, SEL_MIMPID, SEL_MHARTID, SEL_MSTATUSH, SEL_MHZFREQ
    } csr_sel_e;

    typedef struct packed {
        logic        en;
        csr_sel_e    sel;
        logic [31:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] pc;
    } trap_t;

    typedef struct packed {
        logic [31:0] mstatus;
        logic [31:0] mie;
        logic [31:0] mtvec;
        logic [31:0] mscratch;
        logic [31:0] mepc;
        logic [31:0] mcause;
        logic [31:0] mtval;
        logic [31:0] mip;
    } trap_csrs_t;

    typedef logic [NUM_HPM-1:0][63:0] cnt_array_t;

endpackage
